// ==== Bender.yml ====
package:
  name: cfg_chain

sources:
  - design/cfg_chain_pkg.sv
  - design/cfg_bit_counter.sv
  - design/cfg_frame_builder.sv
  - design/cfg_send_fsm.sv
  - design/config_node.sv
  - design/cfg_chain_top.sv
  - target: test
    files:
      - test/cfg_clock_gen.sv
      - test/cfg_chain_checker.sv
      - test/cfg_chain_tb.sv

// ==== design/cfg_bit_counter.sv ====
`timescale 1ns/1ps

module cfg_bit_counter (
  input  logic                               clk_i,
  input  logic                               reset,
  input  logic                               load_i,
  input  logic [cfg_chain_pkg::cfg_len_bits-1:0] value_i,
  input  logic                               dec_i,
  output logic                               zero_o
);

  logic [cfg_chain_pkg::cfg_len_bits-1:0] count_r;

  // a load wins over a decrement, and the count never wraps below zero
  always_ff @(posedge clk_i) begin
    if (reset) begin
      count_r <= '0;
    end else if (load_i) begin
      count_r <= value_i;
    end else if (dec_i && !zero_o) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign zero_o = (count_r == '0);

endmodule

// ==== design/cfg_chain_pkg.sv ====
package cfg_chain_pkg;

  // widths of the node register and the frame fields
  localparam int cfg_data_bits = 16;
  localparam int cfg_frame_len = 8;  // a zero is inserted after this many data bits
  localparam int cfg_id_bits   = 8;
  localparam int cfg_len_bits  = 8;

  // data bits, one inserted zero per data group, and the closing zero
  localparam int cfg_packet_bits = cfg_data_bits + cfg_data_bits / cfg_frame_len + 1;

  // packet, id, length, the start bit and two framing zeros between the fields
  localparam int cfg_shift_bits = cfg_packet_bits + 1 + cfg_id_bits + 1 + cfg_len_bits + 1;

  // the length field counts every bit behind the start bit
  localparam logic [cfg_len_bits-1:0] cfg_frame_rest = cfg_len_bits'(cfg_shift_bits - 1);

  localparam int cfg_num_nodes = 3;  // node ids run from 0 upwards

  typedef logic [cfg_num_nodes-1:0][cfg_data_bits-1:0] cfg_data_array_t;

  // reset value of each node register, entry k belongs to node id k
  localparam cfg_data_array_t cfg_node_default = {16'hFFFF, 16'h1234, 16'h00A5};

  // sender FSM state encoding
  localparam logic [1:0] cfg_st_idle  = 2'd0;
  localparam logic [1:0] cfg_st_send  = 2'd1;
  localparam logic [1:0] cfg_st_guard = 2'd2;

  // the frame is shifted as a plain vector and filled or decoded through its fields
  typedef union packed {
    logic [cfg_shift_bits-1:0] raw;
    struct packed {
      logic [cfg_packet_bits-1:0] data_packet;  // highest bits, sent last
      logic                       frame_zero_hi;
      logic [cfg_id_bits-1:0]     id;
      logic                       frame_zero_lo;
      logic [cfg_len_bits-1:0]    length;
      logic                       start;        // a zero here opens the frame
    } fields;
  } cfg_frame_u;

endpackage

// ==== design/cfg_chain_top.sv ====
`timescale 1ns/1ps

module cfg_chain_top (
  input  logic                                    clk_i,
  input  logic                                    reset,
  input  logic                                    write_i,
  input  logic [cfg_chain_pkg::cfg_id_bits-1:0]   write_id_i,
  input  logic [cfg_chain_pkg::cfg_data_bits-1:0] write_data_i,
  output logic                                    busy_o,
  output cfg_chain_pkg::cfg_data_array_t          node_data_o,
  output logic                                    chain_bit_o
);

  logic load;
  logic shift;
  logic line_bit;   // sender output into the first node
  logic node0_bit;
  logic node1_bit;

  cfg_send_fsm send_fsm0 (
    .clk_i  (clk_i),
    .reset  (reset),
    .write_i(write_i),
    .busy_o (busy_o),
    .load_o (load),
    .shift_o(shift)
  );

  cfg_frame_builder builder0 (
    .clk_i  (clk_i),
    .reset  (reset),
    .load_i (load),
    .shift_i(shift),
    .id_i   (write_id_i),
    .data_i (write_data_i),
    .bit_o  (line_bit)
  );

  // each node adds one frame length of delay along the line
  config_node #(.node_id_p(0)) node0 (
    .clk_i (clk_i),
    .reset (reset),
    .bit_i (line_bit),
    .data_o(node_data_o[0]),
    .bit_o (node0_bit)
  );

  config_node #(.node_id_p(1)) node1 (
    .clk_i (clk_i),
    .reset (reset),
    .bit_i (node0_bit),
    .data_o(node_data_o[1]),
    .bit_o (node1_bit)
  );

  config_node #(.node_id_p(2)) node2 (
    .clk_i (clk_i),
    .reset (reset),
    .bit_i (node1_bit),
    .data_o(node_data_o[2]),
    .bit_o (chain_bit_o)
  );

endmodule

// ==== design/cfg_frame_builder.sv ====
`timescale 1ns/1ps

module cfg_frame_builder (
  input  logic                                   clk_i,
  input  logic                                   reset,
  input  logic                                   load_i,
  input  logic                                   shift_i,
  input  logic [cfg_chain_pkg::cfg_id_bits-1:0]  id_i,
  input  logic [cfg_chain_pkg::cfg_data_bits-1:0] data_i,
  output logic                                   bit_o
);

  import cfg_chain_pkg::*;

  cfg_frame_u frame_n;
  cfg_frame_u frame_r;

  // assemble the frame through the field view
  always_comb begin
    frame_n.fields.start         = 1'b0;
    frame_n.fields.length        = cfg_frame_rest;
    frame_n.fields.frame_zero_lo = 1'b0;
    frame_n.fields.id            = id_i;
    frame_n.fields.frame_zero_hi = 1'b0;
    frame_n.fields.data_packet   = '0;  // framing zeros and the closing zero stay clear

    // each completed group of cfg_frame_len data bits pushes later bits up by one
    for (int i = 0; i < cfg_data_bits; i++) begin
      frame_n.fields.data_packet[i + i / cfg_frame_len] = data_i[i];
    end
  end

  // the idle line is all ones, so the register empties to ones as it shifts
  always_ff @(posedge clk_i) begin
    if (reset) begin
      frame_r.raw <= '1;
    end else if (load_i) begin
      frame_r <= frame_n;
    end else if (shift_i) begin
      frame_r.raw <= {1'b1, frame_r.raw[cfg_shift_bits-1:1]};
    end
  end

  assign bit_o = frame_r.raw[0];  // lsb first onto the chain

endmodule

// ==== design/cfg_send_fsm.sv ====
`timescale 1ns/1ps

module cfg_send_fsm (
  input  logic clk_i,
  input  logic reset,
  input  logic write_i,
  output logic busy_o,
  output logic load_o,
  output logic shift_o
);

  import cfg_chain_pkg::*;

  logic [1:0] state_r;
  logic [1:0] state_n;
  logic       count_zero;

  // counts the 37 bits that follow the start bit
  cfg_bit_counter bit_count0 (
    .clk_i  (clk_i),
    .reset  (reset),
    .load_i (load_o),
    .value_i(cfg_frame_rest),
    .dec_i  (shift_o),
    .zero_o (count_zero)
  );

  always_comb begin
    state_n = state_r;
    case (state_r)
      cfg_st_idle: begin
        if (write_i) begin
          state_n = cfg_st_send;
        end
      end
      cfg_st_send: begin
        // the last frame bit is on the line once the count is spent
        if (count_zero) begin
          state_n = cfg_st_guard;
        end
      end
      cfg_st_guard: state_n = cfg_st_idle;  // one cycle of ones between frames
      default:      state_n = cfg_st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      state_r <= cfg_st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  assign load_o  = (state_r == cfg_st_idle) && write_i;  // writes seen while busy are dropped
  assign shift_o = (state_r == cfg_st_send);
  assign busy_o  = (state_r != cfg_st_idle);

endmodule

// ==== design/config_node.sv ====
`timescale 1ns/1ps

module config_node #(
  parameter int node_id_p = 0
) (
  input  logic                                    clk_i,
  input  logic                                    reset,
  input  logic                                    bit_i,
  output logic [cfg_chain_pkg::cfg_data_bits-1:0] data_o,
  output logic                                    bit_o
);

  import cfg_chain_pkg::*;

  cfg_frame_u                window_r;
  logic                      count_zero;
  logic                      valid;
  logic                      match;
  logic [cfg_data_bits-1:0]  data_n;
  logic [cfg_data_bits-1:0]  data_r;

  // the line enters at the top, so frame bit 0 ends up at position 0
  always_ff @(posedge clk_i) begin
    if (reset) begin
      window_r.raw <= '1;
    end else begin
      window_r.raw <= {bit_i, window_r.raw[cfg_shift_bits-1:1]};
    end
  end

  // skips the rest of a frame so zeros in its body are not taken as a start
  cfg_bit_counter skip_count0 (
    .clk_i  (clk_i),
    .reset  (reset),
    .load_i (valid),
    .value_i(window_r.fields.length),
    .dec_i  (1'b1),
    .zero_o (count_zero)
  );

  assign valid = count_zero && !window_r.fields.start;
  assign match = (window_r.fields.id == cfg_id_bits'(node_id_p));

  // drop the inserted framing zeros from the packet
  always_comb begin
    for (int i = 0; i < cfg_data_bits; i++) begin
      data_n[i] = window_r.fields.data_packet[i + i / cfg_frame_len];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      data_r <= cfg_node_default[node_id_p];
    end else if (valid && match) begin
      data_r <= data_n;
    end
  end

  assign data_o = data_r;
  assign bit_o  = window_r.raw[0];  // every frame passes on unchanged

endmodule

// ==== project.f ====
design/cfg_chain_pkg.sv
design/cfg_bit_counter.sv
design/cfg_frame_builder.sv
design/cfg_send_fsm.sv
design/config_node.sv
design/cfg_chain_top.sv
test/cfg_clock_gen.sv
test/cfg_chain_checker.sv
test/cfg_chain_tb.sv

// ==== test/cfg_chain_checker.sv ====
`timescale 1ns/1ps

module cfg_chain_checker (
  input logic                                  clk_i,
  input logic                                  reset,
  input logic                                  write_i,
  input logic [cfg_chain_pkg::cfg_id_bits-1:0] write_id_i,
  input logic                                  busy_i,
  input cfg_chain_pkg::cfg_data_array_t        node_data_i,
  input logic                                  chain_bit_i
);

  import cfg_chain_pkg::*;

  localparam int busy_cycles  = cfg_shift_bits + 1;                    // frame plus guard cycle
  localparam int load_lag     = cfg_shift_bits + 2;                    // node 0, seen one sample late
  localparam int drain_cycles = cfg_shift_bits * (cfg_num_nodes + 1);  // last bit has left the chain

  int unsigned fail_count = 0;  // the testbench reads this at the end of the run
  int unsigned quiet_cycles;    // cycles since the last accepted write
  logic        accepted;

  assign accepted = write_i && !busy_i;

  always_ff @(posedge clk_i) begin
    if (reset) begin
      quiet_cycles <= drain_cycles;
    end else if (accepted) begin
      quiet_cycles <= 0;
    end else if (quiet_cycles < drain_cycles) begin
      quiet_cycles <= quiet_cycles + 1;
    end
  end

  busy_hold_a: assert property (@(posedge clk_i) disable iff (reset)
    accepted |=> busy_i [*busy_cycles] ##1 !busy_i)
    else begin
      $error("busy_o did not stay high for exactly %0d cycles", busy_cycles);
      fail_count++;
    end

  busy_rise_a: assert property (@(posedge clk_i) disable iff (reset)
    $rose(busy_i) |-> $past(write_i))
    else begin
      $error("busy_o rose without a write strobe");
      fail_count++;
    end

  // with no frame left anywhere in the chain the line idles at one
  idle_line_a: assert property (@(posedge clk_i) disable iff (reset)
    quiet_cycles >= drain_cycles |-> chain_bit_i)
    else begin
      $error("chain_bit_o is low with no frame in flight");
      fail_count++;
    end

  // each further node sees the frame one frame length later
  for (genvar k = 0; k < cfg_num_nodes; k++) begin : g_node
    node_load_a: assert property (@(posedge clk_i) disable iff (reset)
      $changed(node_data_i[k]) |->
        $past(accepted && write_id_i == cfg_id_bits'(k), load_lag + cfg_shift_bits * k))
      else begin
        $error("node %0d changed without a matching write before it", k);
        fail_count++;
      end
  end

endmodule

// ==== test/cfg_chain_tb.sv ====
`timescale 1ns/1ps

module cfg_chain_tb;

  import cfg_chain_pkg::*;

  localparam int wait_limit = 200;  // cycles, more than a frame needs to cross the chain

  logic                      clk;
  logic                      reset;
  logic                      write;
  logic [cfg_id_bits-1:0]    write_id;
  logic [cfg_data_bits-1:0]  write_data;
  logic                      busy;
  cfg_data_array_t           node_data;
  logic                      chain_bit;
  cfg_data_array_t           model;  // expected register of every node
  int                        errors;
  int                        test_errors;
  int                        tests_run;
  int                        tests_failed;

  cfg_clock_gen clock_gen0 (
    .clk_o  (clk),
    .reset_o(reset)
  );

  cfg_chain_top dut0 (
    .clk_i       (clk),
    .reset       (reset),
    .write_i     (write),
    .write_id_i  (write_id),
    .write_data_i(write_data),
    .busy_o      (busy),
    .node_data_o (node_data),
    .chain_bit_o (chain_bit)
  );

  bind cfg_chain_top cfg_chain_checker chain_checker0 (
    .clk_i      (clk_i),
    .reset      (reset),
    .write_i    (write_i),
    .write_id_i (write_id_i),
    .busy_i     (busy_o),
    .node_data_i(node_data_o),
    .chain_bit_i(chain_bit_o)
  );

  // start zero, length 37, zero, id, zero, data low byte, zero, data high byte, two zeros
  function automatic logic [cfg_shift_bits-1:0] expected_frame(input logic [7:0] id,
                                                               input logic [15:0] data);
    return {2'b00, data[15:8], 1'b0, data[7:0], 1'b0, id, 1'b0, 8'd37, 1'b0};
  endfunction

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_model(input string what);
    for (int k = 0; k < cfg_num_nodes; k++) begin
      assert (node_data[k] === model[k])
        else fail_check($sformatf("%s, node %0d holds %h instead of %h",
                                  what, k, node_data[k], model[k]));
    end
  endtask

  task automatic issue_write(input logic [cfg_id_bits-1:0] id,
                             input logic [cfg_data_bits-1:0] data);
    @(posedge clk);
    write      <= 1'b1;
    write_id   <= id;
    write_data <= data;
    @(posedge clk);  // the DUT samples the strobe here
    write <= 1'b0;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (reset !== 1'b0 && n < wait_limit);
    if (reset !== 1'b0) begin
      $display("timeout, reset was still high after %0d cycles", wait_limit);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (busy !== 1'b0 && n < wait_limit);
    if (busy !== 1'b0) begin
      $display("timeout, the sender did not become idle within %0d cycles", wait_limit);
      errors++;
    end
  endtask

  task automatic wait_for_model(output int cycles);
    cycles = 0;
    while (node_data !== model && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (node_data !== model) begin
      $display("timeout, the node registers never reached their expected values");
      errors++;
    end
  endtask

  // returns the edge, counted from the accepting edge, at which the node loaded
  task automatic write_and_land(input int k, input logic [cfg_data_bits-1:0] data,
                                output int load_edge);
    int cycles;
    issue_write(cfg_id_bits'(k), data);
    model[k] = data;
    wait_for_model(cycles);
    load_edge = cycles - 1;
    wait_idle();
    check_model($sformatf("write of %h to node %0d", data, k));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    logic [cfg_data_bits-1:0]  data;
    logic [cfg_shift_bits-1:0] frame;
    logic                      exp_bit;
    int                        load_edge;
    void'($urandom(2));
    write        <= 1'b0;
    write_id     <= '0;
    write_data   <= '0;
    model        = {16'hFFFF, 16'h1234, 16'h00A5};
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;

    wait_reset_release();
    check_model("after reset");
    assert (busy === 1'b0) else fail_check("busy_o is high after reset");
    assert (chain_bit === 1'b1) else fail_check("chain_bit_o is low after reset");
    finish_test("reset values");

    for (int k = 0; k < cfg_num_nodes; k++) begin
      data = cfg_data_bits'($urandom);
      if (data == model[k]) begin
        data = ~data;  // the load has to be visible
      end
      write_and_land(k, data, load_edge);
      assert (load_edge == 39 + 38 * k)
        else fail_check($sformatf("node %0d loaded at edge %0d", k, load_edge));
    end
    finish_test("random writes");

    for (int p = 0; p < 3; p++) begin
      data = (p == 0) ? 16'hFFFF : (p == 1) ? 16'h0000 : 16'hAAAA;
      for (int k = 0; k < cfg_num_nodes; k++) begin
        write_and_land(k, data, load_edge);
      end
    end
    finish_test("zero insertion");

    // no node answers to id 7, the frame only passes through
    data  = cfg_data_bits'($urandom);
    frame = expected_frame(8'd7, data);
    issue_write(8'd7, data);
    for (int m = 0; m < 166; m++) begin
      @(negedge clk);
      exp_bit = (m >= 114 && m < 152) ? frame[m - 114] : 1'b1;
      if (m >= 112) begin
        assert (chain_bit === exp_bit)
          else fail_check($sformatf("chain_bit_o is %b in cycle %0d", chain_bit, m));
      end
    end
    check_model("write to id 7");
    finish_test("unknown id");

    data = ~model[1];
    issue_write(8'd1, data);
    model[1] = data;
    issue_write(8'd0, ~model[0]);  // arrives while busy_o is high
    wait_for_model(load_edge);
    wait_idle();
    check_model("write while busy");
    finish_test("dropped write");

    // node 2 first, so all three frames share the chain
    for (int k = cfg_num_nodes - 1; k >= 0; k--) begin
      data = cfg_data_bits'($urandom);
      issue_write(cfg_id_bits'(k), data);
      model[k] = data;
      wait_idle();
    end
    wait_for_model(load_edge);
    check_model("back-to-back writes");
    finish_test("back to back");

    repeat (2) @(negedge clk);
    $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, dut0.chain_checker0.fail_count);
    if (errors == 0 && dut0.chain_checker0.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== test/cfg_clock_gen.sv ====
`timescale 1ns/1ps

module cfg_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  // reset drops on the eighth rising edge
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule
